/* ccu_pkg.sv */
package ccu_pkg;

  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned LEN_W       = 4;
  localparam int unsigned LINE_OFFS   = 4;
  localparam int unsigned CM_ADDR_W   = ADDR_W - LINE_OFFS;
  localparam int unsigned NUM_PORTS   = 2;
  localparam int unsigned NUM_PATHS   = 2;
  localparam int unsigned PORT_ID_W   = 3;
  localparam int unsigned GRP_ID_W    = PORT_ID_W + 1;
  localparam int unsigned MEM_ID_W    = GRP_ID_W + 1;
  localparam int unsigned TRACK_DEPTH = 4;
  localparam int unsigned DONE_DEPTH  = 2;

  typedef logic [1:0] domain_t;

  // Inner and outer shareable domains are snooped
  localparam domain_t DOMAIN_NONSH  = 2'b00;
  localparam domain_t DOMAIN_INNER  = 2'b01;
  localparam domain_t DOMAIN_OUTER  = 2'b10;
  localparam domain_t DOMAIN_SYSTEM = 2'b11;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LEN_W-1:0]  len_t;

  ////////////////////////////////////////
  // Initiator port
  ////////////////////////////////////////

  typedef struct packed {
    logic [PORT_ID_W-1:0] id;
    addr_t                addr;
    len_t                 len;
    domain_t              domain;
  } port_ar_t;

  typedef struct packed {
    logic [PORT_ID_W-1:0] id;
    data_t                data;
    logic                 last;
  } port_r_t;

  typedef struct packed {
    logic     ar_valid;
    port_ar_t ar;
    logic     r_ready;
    logic     rack;
  } port_req_t;

  typedef struct packed {
    logic    ar_ready;
    logic    r_valid;
    port_r_t r;
  } port_rsp_t;

  ////////////////////////////////////////
  // After a path mux
  ////////////////////////////////////////

  typedef struct packed {
    logic [GRP_ID_W-1:0] id;
    addr_t               addr;
    len_t                len;
    domain_t             domain;
  } grp_ar_t;

  typedef struct packed {
    logic [GRP_ID_W-1:0] id;
    data_t               data;
    logic                last;
  } grp_r_t;

  typedef struct packed {
    logic    ar_valid;
    grp_ar_t ar;
    logic    r_ready;
    logic    rack;
  } grp_req_t;

  typedef struct packed {
    logic   ar_ready;
    logic   r_valid;
    grp_r_t r;
  } grp_rsp_t;

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////

  typedef struct packed {
    logic [MEM_ID_W-1:0] id;
    addr_t               addr;
    len_t                len;
    domain_t             domain;
  } mem_ar_t;

  typedef struct packed {
    logic [MEM_ID_W-1:0] id;
    data_t               data;
    logic                last;
  } mem_r_t;

  typedef struct packed {
    logic    ar_valid;
    mem_ar_t ar;
    logic    r_ready;
    logic    rack;
  } mem_req_t;

  typedef struct packed {
    logic   ar_ready;
    logic   r_valid;
    mem_r_t r;
  } mem_rsp_t;

endpackage

/* ccu_read_demux.sv */
`timescale 1ns/1ps

module ccu_read_demux (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  ccu_pkg::port_req_t                          port_req_i,
  output ccu_pkg::port_rsp_t                          port_rsp_o,
  output ccu_pkg::port_req_t [ccu_pkg::NUM_PATHS-1:0] path_req_o,
  input  ccu_pkg::port_rsp_t [ccu_pkg::NUM_PATHS-1:0] path_rsp_i
);

  import ccu_pkg::*;

  logic       ar_snoop;
  logic       ar_ok;
  logic       ar_hs;
  logic       last_hs;
  logic       cur_path_q;
  logic [2:0] outst_q;

  // Two-entry FIFO of path bits that steers racks
  logic [1:0] rack_path_q;
  logic       rack_rd_q;
  logic       rack_wr_q;
  logic [1:0] rack_cnt_q;
  logic       rack_full;
  logic       rack_empty;
  logic       rack_pop;

  assign ar_snoop = (port_req_i.ar.domain == DOMAIN_INNER) ||
                    (port_req_i.ar.domain == DOMAIN_OUTER);

  // Path change only with nothing in flight
  assign ar_ok = (outst_q != 3'd7) && ((outst_q == 3'd0) || (ar_snoop == cur_path_q));

  assign rack_full  = (rack_cnt_q == 2'd2);
  assign rack_empty = (rack_cnt_q == 2'd0);
  assign rack_pop   = port_req_i.rack && !rack_empty;

  assign ar_hs   = port_req_i.ar_valid && port_rsp_o.ar_ready;
  assign last_hs = port_rsp_o.r_valid && port_req_i.r_ready && port_rsp_o.r.last;

  always_comb begin
    port_rsp_o.ar_ready = ar_ok && path_rsp_i[ar_snoop].ar_ready;
    port_rsp_o.r_valid  = path_rsp_i[cur_path_q].r_valid && !rack_full;
    port_rsp_o.r        = path_rsp_i[cur_path_q].r;
    for (int p = 0; p < NUM_PATHS; p++) begin
      path_req_o[p].ar_valid = port_req_i.ar_valid && ar_ok && (ar_snoop == p[0]);
      path_req_o[p].ar       = port_req_i.ar;
      path_req_o[p].r_ready  = port_req_i.r_ready && !rack_full && (cur_path_q == p[0]);
      path_req_o[p].rack     = rack_pop && (rack_path_q[rack_rd_q] == p[0]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cur_path_q <= 1'b0;
      outst_q    <= 3'd0;
      rack_rd_q  <= 1'b0;
      rack_wr_q  <= 1'b0;
      rack_cnt_q <= 2'd0;
    end else begin
      if (ar_hs) begin
        cur_path_q <= ar_snoop;
      end
      case ({ar_hs, last_hs})
        2'b10:   outst_q <= outst_q + 3'd1;
        2'b01:   outst_q <= outst_q - 3'd1;
        default: outst_q <= outst_q;
      endcase
      if (last_hs) begin
        rack_wr_q <= !rack_wr_q;
      end
      if (rack_pop) begin
        rack_rd_q <= !rack_rd_q;
      end
      case ({last_hs, rack_pop})
        2'b10:   rack_cnt_q <= rack_cnt_q + 2'd1;
        2'b01:   rack_cnt_q <= rack_cnt_q - 2'd1;
        default: rack_cnt_q <= rack_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (last_hs) begin
      rack_path_q[rack_wr_q] <= cur_path_q;
    end
  end

endmodule

/* ccu_read_mux.sv */
`timescale 1ns/1ps

module ccu_read_mux #(
  parameter type slv_req_t = logic,
  parameter type slv_rsp_t = logic,
  parameter type mst_req_t = logic,
  parameter type mst_rsp_t = logic
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  slv_req_t [1:0] slv_req_i,
  output slv_rsp_t [1:0] slv_rsp_o,
  output mst_req_t       mst_req_o,
  input  mst_rsp_t       mst_rsp_i
);

  // Master id carries the input index on top
  localparam int unsigned MST_ID_W = $bits(mst_rsp_i.r.id);
  localparam int unsigned SLV_ID_W = MST_ID_W - 1;

  logic       rr_q;
  logic       lock_q;
  logic       lock_sel_q;
  logic       ar_sel;
  logic       ar_hs;
  logic       r_sel;
  logic       rack_out;
  logic [3:0] rack_cnt_q;
  logic [3:0] rack_cnt_d;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      ar_sel = lock_sel_q;
    end else if (slv_req_i[rr_q].ar_valid) begin
      ar_sel = rr_q;
    end else begin
      ar_sel = !rr_q;
    end
  end

  assign ar_hs = mst_req_o.ar_valid && mst_rsp_i.ar_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q       <= 1'b0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else if (ar_hs) begin
      lock_q <= 1'b0;
      rr_q   <= !ar_sel;
    end else if (mst_req_o.ar_valid) begin
      // Hold the grant until the handshake
      lock_q     <= 1'b1;
      lock_sel_q <= ar_sel;
    end
  end

  ////////////////////////////////////////
  // Requests and responses
  ////////////////////////////////////////

  assign r_sel = mst_rsp_i.r.id[MST_ID_W-1];

  always_comb begin
    mst_req_o.ar_valid  = slv_req_i[ar_sel].ar_valid;
    mst_req_o.ar.id     = {ar_sel, slv_req_i[ar_sel].ar.id};
    mst_req_o.ar.addr   = slv_req_i[ar_sel].ar.addr;
    mst_req_o.ar.len    = slv_req_i[ar_sel].ar.len;
    mst_req_o.ar.domain = slv_req_i[ar_sel].ar.domain;
    mst_req_o.r_ready   = slv_req_i[r_sel].r_ready;
    mst_req_o.rack      = rack_out;
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      slv_rsp_o[i].ar_ready = mst_rsp_i.ar_ready && (ar_sel == i[0]);
      slv_rsp_o[i].r_valid  = mst_rsp_i.r_valid && (r_sel == i[0]);
      slv_rsp_o[i].r.id     = mst_rsp_i.r.id[SLV_ID_W-1:0];
      slv_rsp_o[i].r.data   = mst_rsp_i.r.data;
      slv_rsp_o[i].r.last   = mst_rsp_i.r.last;
    end
  end

  ////////////////////////////////////////
  // Rack merge
  ////////////////////////////////////////

  // Racks beyond one per cycle wait in the counter
  assign rack_out = (rack_cnt_q != 4'd0) || slv_req_i[0].rack || slv_req_i[1].rack;

  assign rack_cnt_d = rack_cnt_q
                    + {3'd0, slv_req_i[0].rack}
                    + {3'd0, slv_req_i[1].rack}
                    - {3'd0, rack_out};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rack_cnt_q <= 4'd0;
    end else begin
      rack_cnt_q <= rack_cnt_d;
    end
  end

endmodule

/* ccu_line_tracker.sv */
`timescale 1ns/1ps

module ccu_line_tracker (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  ccu_pkg::grp_req_t             slv_req_i,
  output ccu_pkg::grp_rsp_t             slv_rsp_o,
  output ccu_pkg::grp_req_t             mst_req_o,
  input  ccu_pkg::grp_rsp_t             mst_rsp_i,
  output logic                          cm_req_o,
  output logic [ccu_pkg::CM_ADDR_W-1:0] cm_addr_o
);

  import ccu_pkg::*;

  typedef logic [$clog2(TRACK_DEPTH)-1:0] idx_t;

  // Table of outstanding snooping reads
  logic [TRACK_DEPTH-1:0]                  valid_q;
  logic [TRACK_DEPTH-1:0]                  done_q;
  logic [TRACK_DEPTH-1:0][TRACK_DEPTH-1:0] older_q;
  logic [TRACK_DEPTH-1:0][GRP_ID_W-1:0]    id_q;
  logic [TRACK_DEPTH-1:0][CM_ADDR_W-1:0]   line_q;

  // Completion queue of table indices
  idx_t [DONE_DEPTH-1:0]             done_idx_q;
  logic [$clog2(DONE_DEPTH)-1:0]     done_rd_q;
  logic [$clog2(DONE_DEPTH)-1:0]     done_wr_q;
  logic [$clog2(DONE_DEPTH+1)-1:0]   done_cnt_q;

  logic                   full;
  logic                   done_full;
  logic                   done_empty;
  logic                   r_hold;
  logic                   ar_hs;
  logic                   last_hs;
  logic                   rack_pop;
  logic [TRACK_DEPTH-1:0] match;
  idx_t                   free_idx;
  idx_t                   match_idx;
  idx_t                   head_idx;
  logic                   cm_req_q;
  logic [CM_ADDR_W-1:0]   cm_addr_q;

  assign full       = &valid_q;
  assign done_full  = (done_cnt_q == DONE_DEPTH);
  assign done_empty = (done_cnt_q == '0);
  assign r_hold     = mst_rsp_i.r.last && done_full;
  assign head_idx   = done_idx_q[done_rd_q];

  always_comb begin
    mst_req_o          = slv_req_i;
    mst_req_o.ar_valid = slv_req_i.ar_valid && !full;
    mst_req_o.r_ready  = slv_req_i.r_ready && !r_hold;
    slv_rsp_o          = mst_rsp_i;
    slv_rsp_o.ar_ready = mst_rsp_i.ar_ready && !full;
    slv_rsp_o.r_valid  = mst_rsp_i.r_valid && !r_hold;
  end

  assign ar_hs    = slv_req_i.ar_valid && slv_rsp_o.ar_ready;
  assign last_hs  = slv_rsp_o.r_valid && slv_req_i.r_ready && mst_rsp_i.r.last;
  assign rack_pop = slv_req_i.rack && !done_empty;

  always_comb begin
    free_idx = '0;
    for (int i = TRACK_DEPTH - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = idx_t'(i);
      end
    end
  end

  // Oldest pending entry with the id of the beat
  always_comb begin
    logic oldest;
    match_idx = '0;
    for (int i = 0; i < TRACK_DEPTH; i++) begin
      match[i] = valid_q[i] && !done_q[i] && (id_q[i] == mst_rsp_i.r.id);
    end
    for (int i = 0; i < TRACK_DEPTH; i++) begin
      oldest = match[i];
      for (int j = 0; j < TRACK_DEPTH; j++) begin
        if (match[j] && older_q[j][i]) begin
          oldest = 1'b0;
        end
      end
      if (oldest) begin
        match_idx = idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q    <= '0;
      done_q     <= '0;
      done_rd_q  <= '0;
      done_wr_q  <= '0;
      done_cnt_q <= '0;
      cm_req_q   <= 1'b0;
    end else begin
      cm_req_q <= rack_pop;
      if (rack_pop) begin
        valid_q[head_idx] <= 1'b0;
        done_rd_q         <= done_rd_q + 1'b1;
      end
      if (ar_hs) begin
        valid_q[free_idx] <= 1'b1;
        done_q[free_idx]  <= 1'b0;
      end
      if (last_hs) begin
        done_q[match_idx] <= 1'b1;
        done_wr_q         <= done_wr_q + 1'b1;
      end
      case ({last_hs, rack_pop})
        2'b10:   done_cnt_q <= done_cnt_q + 1'b1;
        2'b01:   done_cnt_q <= done_cnt_q - 1'b1;
        default: done_cnt_q <= done_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q[free_idx]   <= slv_req_i.ar.id;
      line_q[free_idx] <= slv_req_i.ar.addr[ADDR_W-1:LINE_OFFS];
      // New entry is younger than every live one
      for (int j = 0; j < TRACK_DEPTH; j++) begin
        older_q[free_idx][j] <= 1'b0;
        older_q[j][free_idx] <= valid_q[j];
      end
    end
    if (last_hs) begin
      done_idx_q[done_wr_q] <= match_idx;
    end
    if (rack_pop) begin
      cm_addr_q <= line_q[head_idx];
    end
  end

  assign cm_req_o  = cm_req_q;
  assign cm_addr_o = cm_addr_q;

endmodule

/* ccu_master_path.sv */
`timescale 1ns/1ps

module ccu_master_path (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  ccu_pkg::port_req_t [ccu_pkg::NUM_PORTS-1:0] port_req_i,
  output ccu_pkg::port_rsp_t [ccu_pkg::NUM_PORTS-1:0] port_rsp_o,
  output ccu_pkg::mem_req_t                           mem_req_o,
  input  ccu_pkg::mem_rsp_t                           mem_rsp_i,
  output logic                                        cm_req_o,
  output logic [ccu_pkg::CM_ADDR_W-1:0]               cm_addr_o
);

  import ccu_pkg::*;

  port_req_t [NUM_PORTS-1:0] snp_req;
  port_rsp_t [NUM_PORTS-1:0] snp_rsp;
  port_req_t [NUM_PORTS-1:0] nsnp_req;
  port_rsp_t [NUM_PORTS-1:0] nsnp_rsp;

  grp_req_t snp_mux_req;
  grp_rsp_t snp_mux_rsp;
  grp_req_t snp_trk_req;
  grp_rsp_t snp_trk_rsp;
  grp_req_t nsnp_mux_req;
  grp_rsp_t nsnp_mux_rsp;

  ////////////////////////////////////////
  // Demux
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_demux
    ccu_read_demux i_demux (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .port_req_i (port_req_i[i]),
      .port_rsp_o (port_rsp_o[i]),
      .path_req_o ({snp_req[i], nsnp_req[i]}),
      .path_rsp_i ({snp_rsp[i], nsnp_rsp[i]})
    );
  end

  ////////////////////////////////////////
  // Snooping path
  ////////////////////////////////////////

  ccu_read_mux #(
    .slv_req_t (port_req_t),
    .slv_rsp_t (port_rsp_t),
    .mst_req_t (grp_req_t),
    .mst_rsp_t (grp_rsp_t)
  ) i_snoop_mux (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .slv_req_i (snp_req),
    .slv_rsp_o (snp_rsp),
    .mst_req_o (snp_mux_req),
    .mst_rsp_i (snp_mux_rsp)
  );

  ccu_line_tracker i_tracker (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .slv_req_i (snp_mux_req),
    .slv_rsp_o (snp_mux_rsp),
    .mst_req_o (snp_trk_req),
    .mst_rsp_i (snp_trk_rsp),
    .cm_req_o  (cm_req_o),
    .cm_addr_o (cm_addr_o)
  );

  ////////////////////////////////////////
  // Non-snooping path and final mux
  ////////////////////////////////////////

  ccu_read_mux #(
    .slv_req_t (port_req_t),
    .slv_rsp_t (port_rsp_t),
    .mst_req_t (grp_req_t),
    .mst_rsp_t (grp_rsp_t)
  ) i_nosnoop_mux (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .slv_req_i (nsnp_req),
    .slv_rsp_o (nsnp_rsp),
    .mst_req_o (nsnp_mux_req),
    .mst_rsp_i (nsnp_mux_rsp)
  );

  // Input 1 is the snooping path and sets the top id bit
  ccu_read_mux #(
    .slv_req_t (grp_req_t),
    .slv_rsp_t (grp_rsp_t),
    .mst_req_t (mem_req_t),
    .mst_rsp_t (mem_rsp_t)
  ) i_final_mux (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .slv_req_i ({snp_trk_req, nsnp_mux_req}),
    .slv_rsp_o ({snp_trk_rsp, nsnp_mux_rsp}),
    .mst_req_o (mem_req_o),
    .mst_rsp_i (mem_rsp_i)
  );

endmodule

/* ccu_checker.sv */
`timescale 1ns/1ps

module ccu_checker (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  ccu_pkg::port_req_t [ccu_pkg::NUM_PORTS-1:0] port_req_i,
  input  ccu_pkg::port_rsp_t [ccu_pkg::NUM_PORTS-1:0] port_rsp_i,
  input  ccu_pkg::mem_req_t                           mem_req_i,
  input  ccu_pkg::mem_rsp_t                           mem_rsp_i,
  input  logic                                        cm_req_i,
  input  logic [ccu_pkg::CM_ADDR_W-1:0]               cm_addr_i,
  output int                                          err_cnt_o,
  output int                                          rd_cnt_o,
  output int                                          cm_cnt_o,
  output logic                                        busy_o
);

  import ccu_pkg::*;

  localparam int unsigned IDS         = 1 << PORT_ID_W;
  localparam int unsigned SLOTS       = NUM_PORTS * IDS;
  localparam int unsigned STALL_LIMIT = 3000;

  typedef struct packed {
    addr_t addr;
    len_t  len;
    logic  snoop;
  } exp_t;

  // Open reads per port and id in issue order
  exp_t                 exp_q [SLOTS][$];
  int unsigned          beat_cnt [SLOTS];
  logic [CM_ADDR_W-1:0] cm_exp_q [$];

  int   err_cnt;
  int   rd_cnt;
  int   cm_cnt;
  int   open_cnt;
  int   idle_cnt;
  int   mem_rack_open;
  logic seen_req;
  logic any_beat;
  exp_t ent;
  int   slot;
  logic exp_last;
  data_t exp_data;
  logic [CM_ADDR_W-1:0] exp_line;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic data_t expected_data(addr_t addr, int unsigned beat);
    return (addr + addr_t'(beat * 4)) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic logic is_snoop(domain_t dom);
    return (dom == DOMAIN_INNER) || (dom == DOMAIN_OUTER);
  endfunction

  task automatic report_mismatch(string name, logic [31:0] exp_val, logic [31:0] act_val);
    $display("mismatch %s: expected %h actual %h", name, exp_val, act_val);
    err_cnt++;
  endtask

  task automatic flag_error(string msg);
    $display("error: %s", msg);
    err_cnt++;
  endtask

  ////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      seen_req      = 1'b0;
      open_cnt      = 0;
      idle_cnt      = 0;
      mem_rack_open = 0;
    end else begin
      any_beat = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (port_req_i[p].ar_valid) begin
          seen_req = 1'b1;
        end
      end
      if (!seen_req) begin
        if (cm_req_i || mem_req_i.ar_valid || port_rsp_i[0].r_valid || port_rsp_i[1].r_valid) begin
          flag_error("output active after reset before any request");
        end
      end

      for (int p = 0; p < NUM_PORTS; p++) begin
        if (port_req_i[p].ar_valid && port_rsp_i[p].ar_ready) begin
          slot = p * IDS + int'(port_req_i[p].ar.id);
          ent.addr  = port_req_i[p].ar.addr;
          ent.len   = port_req_i[p].ar.len;
          ent.snoop = is_snoop(port_req_i[p].ar.domain);
          exp_q[slot].push_back(ent);
          open_cnt++;
        end
        if (port_rsp_i[p].r_valid && port_req_i[p].r_ready) begin
          any_beat = 1'b1;
          slot = p * IDS + int'(port_rsp_i[p].r.id);
          if (exp_q[slot].size() == 0) begin
            flag_error($sformatf("beat on port %0d id %0d with no open read",
                                 p, port_rsp_i[p].r.id));
          end else begin
            ent      = exp_q[slot][0];
            exp_data = expected_data(ent.addr, beat_cnt[slot]);
            exp_last = (beat_cnt[slot] == int'(ent.len));
            if (port_rsp_i[p].r.data !== exp_data) begin
              report_mismatch($sformatf("read_data port %0d", p), exp_data,
                              port_rsp_i[p].r.data);
            end
            if (port_rsp_i[p].r.last !== exp_last) begin
              report_mismatch($sformatf("read_last port %0d", p), {31'd0, exp_last},
                              {31'd0, port_rsp_i[p].r.last});
            end
            if (exp_last) begin
              void'(exp_q[slot].pop_front());
              beat_cnt[slot] = 0;
              rd_cnt++;
              open_cnt--;
              if (ent.snoop) begin
                cm_exp_q.push_back(ent.addr[ADDR_W-1:LINE_OFFS]);
              end
            end else begin
              beat_cnt[slot]++;
            end
          end
        end
      end

      // Top id bit at memory tells the path
      if (mem_req_i.ar_valid && mem_rsp_i.ar_ready) begin
        if (mem_req_i.ar.id[MEM_ID_W-1] !== is_snoop(mem_req_i.ar.domain)) begin
          report_mismatch("mem_path", {31'd0, is_snoop(mem_req_i.ar.domain)},
                          {31'd0, mem_req_i.ar.id[MEM_ID_W-1]});
        end
      end

      // Each read at memory gets one rack after its last beat
      if (mem_req_i.rack) begin
        if (mem_rack_open == 0) begin
          flag_error("read acknowledge at memory without a completed read");
        end else begin
          mem_rack_open--;
        end
      end
      if (mem_rsp_i.r_valid && mem_req_i.r_ready && mem_rsp_i.r.last) begin
        mem_rack_open++;
      end

      if (cm_req_i) begin
        cm_cnt++;
        if (cm_exp_q.size() == 0) begin
          flag_error("coherence monitor pulse without a completed snooping read");
        end else begin
          exp_line = cm_exp_q.pop_front();
          if (cm_addr_i !== exp_line) begin
            report_mismatch("cm_addr", {4'd0, exp_line}, {4'd0, cm_addr_i});
          end
        end
      end

      // Watchdog on returning data
      if (open_cnt > 0 && !any_beat) begin
        idle_cnt++;
        if (idle_cnt == STALL_LIMIT) begin
          flag_error("no read data returned for too many cycles");
        end
      end else begin
        idle_cnt = 0;
      end
    end
    busy_o <= (open_cnt != 0) || (cm_exp_q.size() != 0) || (mem_rack_open != 0);
  end

  assign err_cnt_o = err_cnt;
  assign rd_cnt_o  = rd_cnt;
  assign cm_cnt_o  = cm_cnt;

endmodule

/* tb_ccu_master_path.sv */
`timescale 1ns/1ps

module tb_ccu_master_path;

  import ccu_pkg::*;

  localparam int unsigned NUM_READS   = 40;
  localparam int unsigned DRAIN_LIMIT = 200000;

  typedef struct packed {
    logic [MEM_ID_W-1:0] id;
    addr_t               addr;
    len_t                len;
  } mem_cmd_t;

  logic                      clk_i   = 1'b0;
  logic                      rst_n_i = 1'b0;
  port_req_t [NUM_PORTS-1:0] port_req = '0;
  port_rsp_t [NUM_PORTS-1:0] port_rsp;
  mem_req_t                  mem_req;
  mem_rsp_t                  mem_rsp = '0;
  logic                      cm_req;
  logic [CM_ADDR_W-1:0]      cm_addr;

  int          err_cnt;
  int          rd_cnt;
  int          cm_cnt;
  logic        busy;
  int          issued [NUM_PORTS];
  int unsigned cyc;
  logic        stall;
  logic [31:0] rnd;
  mem_cmd_t    mem_q [$];
  mem_cmd_t    head;
  int unsigned mem_beat;
  logic        fire;
  logic        drained;
  int unsigned wait_cnt;

  ccu_master_path i_dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .port_req_i (port_req),
    .port_rsp_o (port_rsp),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp),
    .cm_req_o   (cm_req),
    .cm_addr_o  (cm_addr)
  );

  ccu_checker i_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .port_req_i (port_req),
    .port_rsp_i (port_rsp),
    .mem_req_i  (mem_req),
    .mem_rsp_i  (mem_rsp),
    .cm_req_i   (cm_req),
    .cm_addr_i  (cm_addr),
    .err_cnt_o  (err_cnt),
    .rd_cnt_o   (rd_cnt),
    .cm_cnt_o   (cm_cnt),
    .busy_o     (busy)
  );

  initial begin
    forever #50 clk_i = !clk_i;
  end

  // Long back-pressure windows every third slot
  assign stall = ((cyc / 150) % 3) == 2;

  ////////////////////////////////////////
  // Initiator ports
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      port_req <= '0;
      cyc      <= 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        issued[p] <= 0;
      end
    end else begin
      cyc <= cyc + 1;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (port_req[p].ar_valid && port_rsp[p].ar_ready) begin
          issued[p]            <= issued[p] + 1;
          port_req[p].ar_valid <= 1'b0;
        end else if (!port_req[p].ar_valid && issued[p] < NUM_READS && $urandom % 3 == 0) begin
          port_req[p].ar_valid <= 1'b1;
          rnd = $urandom;
          port_req[p].ar.id     <= rnd[2:0];
          port_req[p].ar.len    <= {2'b00, rnd[4:3]};
          port_req[p].ar.domain <= rnd[6:5];
          port_req[p].ar.addr   <= $urandom;
        end
        port_req[p].r_ready <= stall ? ($urandom % 8 == 0) : ($urandom % 4 != 0);
        // Rack follows each accepted last beat
        port_req[p].rack <= port_rsp[p].r_valid && port_req[p].r_ready && port_rsp[p].r.last;
      end
    end
  end

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_rsp  <= '0;
      mem_beat = 0;
    end else begin
      if (mem_req.ar_valid && mem_rsp.ar_ready) begin
        mem_q.push_back({mem_req.ar.id, mem_req.ar.addr, mem_req.ar.len});
      end
      mem_rsp.ar_ready <= stall ? ($urandom % 8 == 0) : ($urandom % 4 != 0);
      fire = mem_rsp.r_valid && mem_req.r_ready;
      if (fire) begin
        if (mem_rsp.r.last) begin
          void'(mem_q.pop_front());
          mem_beat = 0;
        end else begin
          mem_beat++;
        end
      end
      if (fire || !mem_rsp.r_valid) begin
        if (mem_q.size() > 0 && $urandom % 3 != 0) begin
          head = mem_q[0];
          mem_rsp.r_valid <= 1'b1;
          mem_rsp.r.id    <= head.id;
          mem_rsp.r.data  <= i_checker.expected_data(head.addr, mem_beat);
          mem_rsp.r.last  <= (mem_beat == int'(head.len));
        end else begin
          mem_rsp.r_valid <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////

  initial begin
    void'($urandom(50511));
    drained = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (wait_cnt = 0; wait_cnt < DRAIN_LIMIT && !drained; wait_cnt++) begin
      @(posedge clk_i);
      drained = (issued[0] == NUM_READS) && (issued[1] == NUM_READS) && !busy;
    end
    if (!drained) begin
      $display("error: timeout while waiting for all reads to complete");
    end
    // Quiet tail to catch stray coherence pulses
    repeat (20) @(posedge clk_i);
    $display("errors %0d, reads %0d, cm pulses %0d", err_cnt, rd_cnt, cm_cnt);
    if (drained && err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* sim.f */
ccu_pkg.sv
ccu_read_demux.sv
ccu_read_mux.sv
ccu_line_tracker.sv
ccu_master_path.sv
ccu_checker.sv
tb_ccu_master_path.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_ccu_master_path -o sim \
  && ./obj_dir/sim > sim.log 2>&1 \
  ; grep -q "^Regression passed$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
